//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_compute_tile
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

# build, run, and pass only if the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_compute_tile.sv
`default_nettype none

module tb_compute_tile;

  import tile_pkg::*;

  localparam logic [X_CORD_W-1:0] MY_X = 4'd5;
  localparam logic [Y_CORD_W-1:0] MY_Y = 4'd6;
  localparam int WAIT_LIMIT = 40;

  // one packet the model expects on a mesh output
  typedef struct packed {
    int      dir;
    int      cyc;
    packet_t pkt;
  } exp_t;

  logic                   clk;
  logic                   rst_n_i;
  logic                   rst_n_o;
  logic [NUM_DIRS-1:0]    link_v_i;
  packet_t [NUM_DIRS-1:0] link_data_i;
  logic [NUM_DIRS-1:0]    link_v_o;
  packet_t [NUM_DIRS-1:0] link_data_o;
  logic [NUM_DIRS-1:0]    barrier_link_i;
  logic [NUM_DIRS-1:0]    barrier_link_o;
  logic [X_CORD_W-1:0]    global_x_i;
  logic [Y_CORD_W-1:0]    global_y_i;
  logic [X_CORD_W-1:0]    global_x_o;
  logic [Y_CORD_W-1:0]    global_y_o;

  int                  cyc = 0;
  int                  errors = 0;
  int                  tests_run = 0;
  int                  tests_failed = 0;
  logic [X_CORD_W-1:0] gx_cap;
  logic [Y_CORD_W-1:0] gy_cap;
  logic                coord_ok = 1'b0;
  exp_t                exp_q [$];
  logic [DATA_W-1:0]   mem_model [DMEM_WORDS];

  compute_tile i_compute_tile (
    .clk_i         (clk),
    .rst_n_i       (rst_n_i),
    .rst_n_o       (rst_n_o),
    .link_v_i      (link_v_i),
    .link_data_i   (link_data_i),
    .link_v_o      (link_v_o),
    .link_data_o   (link_data_o),
    .barrier_link_i(barrier_link_i),
    .barrier_link_o(barrier_link_o),
    .global_x_i    (global_x_i),
    .global_y_i    (global_y_i),
    .global_x_o    (global_x_o),
    .global_y_o    (global_y_o)
  );

  always #4 clk = ~clk;

  // what the tile captured this edge
  always @(posedge clk) begin
    gx_cap   <= global_x_i;
    gy_cap   <= global_y_i;
    coord_ok <= 1'b1;
    cyc      <= cyc + 1;
  end

  function automatic void report(input string msg);
    errors++;
    $display("%s", msg);
  endfunction

  // XY rule seen from this tile
  function automatic int route_of(input packet_t p);
    if (p.dest_x > MY_X) return DIR_E;
    if (p.dest_x < MY_X) return DIR_W;
    if (p.dest_y > MY_Y) return DIR_S;
    if (p.dest_y < MY_Y) return DIR_N;
    return PORT_P;
  endfunction

  function automatic packet_t rand_transit();
    packet_t p;
    p.op    = op_e'(3'($urandom_range(0, 4)));
    p.src_x = 4'($urandom);
    p.src_y = 4'($urandom);
    p.addr  = 4'($urandom);
    p.data  = $urandom;
    do begin
      p.dest_x = 4'($urandom);
      p.dest_y = 4'($urandom);
    end while (p.dest_x == MY_X && p.dest_y == MY_Y);
    return p;
  endfunction

  always @(negedge clk) begin
    int                  idx;
    logic [Y_CORD_W-1:0] exp_y;
    if (rst_n_o) begin
      for (int d = 0; d < NUM_DIRS; d++) begin
        if (link_v_o[d]) begin
          idx = -1;
          for (int i = 0; i < exp_q.size(); i++) begin
            if (idx < 0 && exp_q[i].dir == d) idx = i;
          end
          assert (idx >= 0)
            else report($sformatf("unexpected packet on link %0d: %h", d, link_data_o[d]));
          if (idx >= 0) begin
            assert (exp_q[idx].cyc == cyc) else report($sformatf(
              "Fail link_v_o[%0d] cycle: got %h expected %h", d, cyc, exp_q[idx].cyc));
            assert (link_data_o[d] == exp_q[idx].pkt) else report($sformatf(
              "Fail link_data_o[%0d]: got %h expected %h", d, link_data_o[d], exp_q[idx].pkt));
            exp_q.delete(idx);
          end
        end
      end
      // overdue entries were lost in the tile
      for (int i = exp_q.size() - 1; i >= 0; i--) begin
        assert (exp_q[i].cyc >= cyc) else begin
          report($sformatf("packet for link %0d never arrived: %h", exp_q[i].dir,
                           exp_q[i].pkt));
          exp_q.delete(i);
        end
      end
    end else if (cyc > 0) begin
      assert (link_v_o == '0) else report($sformatf(
        "Fail link_v_o in reset: got %h expected %h", link_v_o, 4'h0));
      assert (barrier_link_o == '0) else report($sformatf(
        "Fail barrier_link_o in reset: got %h expected %h", barrier_link_o, 4'h0));
    end
    if (coord_ok) begin
      exp_y = gy_cap + 4'd1;
      assert (global_x_o == gx_cap) else report($sformatf(
        "Fail global_x_o: got %h expected %h", global_x_o, gx_cap));
      assert (global_y_o == exp_y) else report($sformatf(
        "Fail global_y_o: got %h expected %h", global_y_o, exp_y));
    end
  end

  task automatic next_cycle();
    @(negedge clk);
    link_v_i = '0;
  endtask

  task automatic drive(input int d, input packet_t p);
    link_v_i[d]    = 1'b1;
    link_data_i[d] = p;
  endtask

  task automatic expect_pkt(input int d, input packet_t p, input int lat);
    exp_t e;
    e.dir = d;
    e.cyc = cyc + lat;
    e.pkt = p;
    exp_q.push_back(e);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    assert (exp_q.size() == 0) else begin
      report($sformatf("timeout with %0d packets still expected", exp_q.size()));
      exp_q.delete();
    end
  endtask

  task automatic wait_barrier(input int d, input logic level, input string what,
                              output int waited);
    waited = 0;
    while (barrier_link_o[d] !== level && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    assert (barrier_link_o[d] === level) else report($sformatf("timeout waiting for %s", what));
  endtask

  task automatic end_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err_start);
    end
  endtask

  task automatic test_reset();
    int err0;
    int start;
    int n;
    err0 = errors;
    repeat (5) @(negedge clk);
    rst_n_i = 1'b1;
    start   = cyc;
    // half a phase later the synchronizer has seen no edge yet
    #2;
    assert (rst_n_o === 1'b0) else report("rst_n_o left reset before a clock edge");
    n = 0;
    while (rst_n_o !== 1'b1 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    assert (rst_n_o === 1'b1) else report("timeout waiting for rst_n_o to deassert");
    assert (cyc == start + 1) else report($sformatf(
      "Fail rst_n_o delay: got %h expected %h", cyc - start, 1));
    assert (link_v_o == '0 && barrier_link_o == '0)
      else report("valid or barrier outputs high right after reset");
    // walk the coordinates, then force the y wrap
    repeat (6) begin
      @(negedge clk);
      global_x_i = 4'($urandom);
      global_y_i = 4'($urandom);
    end
    @(negedge clk);
    global_y_i = 4'hf;
    @(negedge clk);
    global_x_i = MY_X;
    global_y_i = MY_Y;
    repeat (2) @(negedge clk);
    end_test("reset", err0);
  endtask

  task automatic test_transit();
    int      err0;
    int      d;
    packet_t p;
    err0 = errors;
    // one packet per cycle keeps the outputs free of contention
    repeat (24) begin
      next_cycle();
      d = int'($urandom_range(0, 3));
      p = rand_transit();
      drive(d, p);
      expect_pkt(route_of(p), p, 2);
    end
    next_cycle();
    wait_drain();
    end_test("transit", err0);
  endtask

  task automatic test_memory();
    int                err0;
    int                d;
    packet_t           p;
    packet_t           r;
    logic [ADDR_W-1:0] stored [$];
    err0 = errors;
    repeat (6) begin
      next_cycle();
      p        = rand_transit();
      p.op     = OP_STORE;
      p.dest_x = MY_X;
      p.dest_y = MY_Y;
      mem_model[p.addr] = p.data;
      stored.push_back(p.addr);
      drive(int'($urandom_range(0, 3)), p);
    end
    repeat (4) next_cycle();
    foreach (stored[i]) begin
      next_cycle();
      d = int'($urandom_range(0, 3));
      p = rand_transit();
      p.op     = OP_LOAD;
      p.dest_x = MY_X;
      p.dest_y = MY_Y;
      p.addr   = stored[i];
      // source is the neighbor on the arrival side
      p.src_x  = MY_X;
      p.src_y  = MY_Y;
      if (d == DIR_W) p.src_x = MY_X - 4'd1;
      if (d == DIR_E) p.src_x = MY_X + 4'd1;
      if (d == DIR_N) p.src_y = MY_Y - 4'd1;
      if (d == DIR_S) p.src_y = MY_Y + 4'd1;
      drive(d, p);
      r.op     = OP_REPLY;
      r.dest_x = p.src_x;
      r.dest_y = p.src_y;
      r.src_x  = MY_X;
      r.src_y  = MY_Y;
      r.addr   = p.addr;
      r.data   = mem_model[p.addr];
      expect_pkt(route_of(r), r, 5);
    end
    next_cycle();
    wait_drain();
    end_test("store_load", err0);
  endtask

  task automatic test_contention();
    int      err0;
    packet_t p;
    err0 = errors;
    repeat (2) begin
      next_cycle();
      p = rand_transit();
      p.dest_x = 4'($urandom_range(6, 15));
      drive(DIR_W, p);
      expect_pkt(DIR_E, p, 2);
      p = rand_transit();
      p.dest_x = 4'($urandom_range(6, 15));
      drive(DIR_N, p);
      expect_pkt(DIR_E, p, 3);
      p = rand_transit();
      p.dest_x = 4'($urandom_range(6, 15));
      drive(DIR_S, p);
      expect_pkt(DIR_E, p, 4);
      next_cycle();
      wait_drain();
    end
    end_test("contention", err0);
  endtask

  task automatic test_barrier();
    int      err0;
    int      n;
    packet_t p;
    err0 = errors;
    next_cycle();
    p = '0;
    p.op     = OP_BAR_CFG;
    p.dest_x = MY_X;
    p.dest_y = MY_Y;
    // mask P and W, destination E
    p.data   = 32'h31;
    drive(DIR_N, p);
    next_cycle();
    p.op   = OP_BAR_JOIN;
    p.data = '0;
    drive(DIR_N, p);
    next_cycle();
    repeat (6) begin
      @(negedge clk);
      assert (barrier_link_o == '0) else report($sformatf(
        "Fail barrier_link_o before gather: got %h expected %h", barrier_link_o, 4'h0));
    end
    barrier_link_i[DIR_W] = 1'b1;
    wait_barrier(DIR_E, 1'b1, "gather on barrier_link_o[E]", n);
    assert (n == 1) else report($sformatf(
      "Fail barrier_link_o[E] delay: got %h expected %h", n, 1));
    assert (barrier_link_o[DIR_W] == 1'b0) else report("release seen before the root answered");
    barrier_link_i[DIR_E] = 1'b1;
    wait_barrier(DIR_W, 1'b1, "release on barrier_link_o[W]", n);
    assert (n == 1) else report($sformatf(
      "Fail barrier_link_o[W] delay: got %h expected %h", n, 1));
    // join clears, so the gather drops
    wait_barrier(DIR_E, 1'b0, "barrier_link_o[E] to fall after release", n);
    barrier_link_i = '0;
    wait_barrier(DIR_W, 1'b0, "barrier_link_o[W] to fall", n);
    end_test("barrier", err0);
  endtask

  initial begin
    void'($urandom(32'he87d9293));
    clk            = 1'b0;
    rst_n_i        = 1'b0;
    link_v_i       = '0;
    link_data_i    = '0;
    barrier_link_i = '0;
    global_x_i     = MY_X;
    global_y_i     = MY_Y;
    test_reset();
    test_transit();
    test_memory();
    test_contention();
    test_barrier();
    repeat (2) @(negedge clk);
    $display("tests run %0d, tests failed %0d, failed checks %0d", tests_run, tests_failed,
             errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
hw/tile_pkg.sv
hw/link_fifo.sv
hw/mesh_router.sv
hw/barrier_node.sv
hw/tile_socket.sv
hw/compute_tile.sv
bench/tb_compute_tile.sv

//--- hw/barrier_node.sv
`default_nettype none

module barrier_node (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             join_i,
  input  logic [tile_pkg::NUM_PORTS-1:0]  src_mask_i,
  input  logic [tile_pkg::PORT_SEL_W-1:0] dest_i,
  input  logic [tile_pkg::NUM_DIRS-1:0]   link_i,
  output logic [tile_pkg::NUM_DIRS-1:0]   link_o,
  output logic                             release_o
);

  import tile_pkg::*;

  logic                cfg_v;
  logic                mesh_in;
  logic                gather;
  logic                rel;
  logic                rel_r;
  logic [NUM_DIRS-1:0] link_next;

  // an empty mask means the node takes no part
  assign cfg_v   = |src_mask_i;
  assign mesh_in = &(link_i | ~src_mask_i[NUM_DIRS-1:0]);
  assign gather  = cfg_v && mesh_in && (join_i || !src_mask_i[PORT_P]);

  // root node releases on its own gather
  always_comb begin
    if (!cfg_v) begin
      rel = 1'b0;
    end else if (dest_i == PORT_SEL_W'(PORT_P)) begin
      rel = gather;
    end else if (dest_i < PORT_SEL_W'(NUM_DIRS)) begin
      rel = link_i[dest_i[1:0]];
    end else begin
      rel = 1'b0;
    end
  end

  // gather goes up, release fans back out
  always_comb begin
    for (int d = 0; d < NUM_DIRS; d++) begin
      link_next[d] = (gather && dest_i == PORT_SEL_W'(d)) || (src_mask_i[d] && rel);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      link_o    <= '0;
      rel_r     <= 1'b0;
      release_o <= 1'b0;
    end else begin
      link_o    <= link_next;
      rel_r     <= rel;
      release_o <= rel && !rel_r;
    end
  end

endmodule

`default_nettype wire

//--- hw/compute_tile.sv
`default_nettype none

module compute_tile (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  output logic                                       rst_n_o,
  input  logic              [tile_pkg::NUM_DIRS-1:0] link_v_i,
  input  tile_pkg::packet_t [tile_pkg::NUM_DIRS-1:0] link_data_i,
  output logic              [tile_pkg::NUM_DIRS-1:0] link_v_o,
  output tile_pkg::packet_t [tile_pkg::NUM_DIRS-1:0] link_data_o,
  input  logic              [tile_pkg::NUM_DIRS-1:0] barrier_link_i,
  output logic              [tile_pkg::NUM_DIRS-1:0] barrier_link_o,
  input  logic              [tile_pkg::X_CORD_W-1:0] global_x_i,
  input  logic              [tile_pkg::Y_CORD_W-1:0] global_y_i,
  output logic              [tile_pkg::X_CORD_W-1:0] global_x_o,
  output logic              [tile_pkg::Y_CORD_W-1:0] global_y_o
);

  import tile_pkg::*;

  logic                           rst_n_r;
  logic [X_CORD_W-1:0]            my_x_r;
  logic [Y_CORD_W-1:0]            my_y_r;
  logic    [NUM_PORTS-1:0]        rtr_in_v;
  packet_t [NUM_PORTS-1:0]        rtr_in_data;
  logic    [NUM_PORTS-1:0]        rtr_out_v;
  packet_t [NUM_PORTS-1:0]        rtr_out_data;
  logic                           reply_v;
  packet_t                        reply_data;
  logic                           bar_join;
  logic [NUM_PORTS-1:0]           bar_src_mask;
  logic [PORT_SEL_W-1:0]          bar_dest;
  logic                           bar_release;

  // local reset, asserts at once and leaves on a clock edge
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rst_n_r <= 1'b0;
    end else begin
      rst_n_r <= 1'b1;
    end
  end

  assign rst_n_o = rst_n_r;

  always_ff @(posedge clk_i) begin
    my_x_r <= global_x_i;
    my_y_r <= global_y_i;
  end

  // next tile south sits one row down
  assign global_x_o = my_x_r;
  assign global_y_o = Y_CORD_W'(my_y_r + 1'b1);

  // mesh on ports 0..3, socket on port P
  assign rtr_in_v    = {reply_v, link_v_i};
  assign rtr_in_data = {reply_data, link_data_i};
  assign link_v_o    = rtr_out_v[NUM_DIRS-1:0];
  assign link_data_o = rtr_out_data[NUM_DIRS-1:0];

  mesh_router i_mesh_router (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_r),
    .my_x_i    (my_x_r),
    .my_y_i    (my_y_r),
    .in_v_i    (rtr_in_v),
    .in_data_i (rtr_in_data),
    .out_v_o   (rtr_out_v),
    .out_data_o(rtr_out_data)
  );

  barrier_node i_barrier_node (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_r),
    .join_i    (bar_join),
    .src_mask_i(bar_src_mask),
    .dest_i    (bar_dest),
    .link_i    (barrier_link_i),
    .link_o    (barrier_link_o),
    .release_o (bar_release)
  );

  tile_socket i_tile_socket (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_r),
    .my_x_i        (my_x_r),
    .my_y_i        (my_y_r),
    .req_v_i       (rtr_out_v[PORT_P]),
    .req_data_i    (rtr_out_data[PORT_P]),
    .reply_v_o     (reply_v),
    .reply_data_o  (reply_data),
    .bar_join_o    (bar_join),
    .bar_src_mask_o(bar_src_mask),
    .bar_dest_o    (bar_dest),
    .bar_release_i (bar_release)
  );

endmodule

`default_nettype wire

//--- hw/link_fifo.sv
`default_nettype none

module link_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     wr_v_i,
  input  payload_t wr_data_i,
  input  logic     rd_i,
  output logic     empty_o,
  output logic     full_o,
  output payload_t rd_data_o
);

  payload_t   slot_r [2];
  logic       wr_ptr_r;
  logic       rd_ptr_r;
  logic [1:0] count_r;
  logic       do_wr;
  logic       do_rd;

  assign empty_o = (count_r == 2'd0);
  assign full_o  = (count_r == 2'd2);

  // writes into a full queue are dropped
  assign do_wr = wr_v_i && !full_o;
  assign do_rd = rd_i && !empty_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end else begin
      if (do_wr) wr_ptr_r <= ~wr_ptr_r;
      if (do_rd) rd_ptr_r <= ~rd_ptr_r;
      count_r <= count_r + {1'b0, do_wr} - {1'b0, do_rd};
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_wr) slot_r[wr_ptr_r] <= wr_data_i;
  end

  assign rd_data_o = slot_r[rd_ptr_r];

endmodule

`default_nettype wire

//--- hw/mesh_router.sv
`default_nettype none

module mesh_router (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  logic              [tile_pkg::X_CORD_W-1:0]  my_x_i,
  input  logic              [tile_pkg::Y_CORD_W-1:0]  my_y_i,
  input  logic              [tile_pkg::NUM_PORTS-1:0] in_v_i,
  input  tile_pkg::packet_t [tile_pkg::NUM_PORTS-1:0] in_data_i,
  output logic              [tile_pkg::NUM_PORTS-1:0] out_v_o,
  output tile_pkg::packet_t [tile_pkg::NUM_PORTS-1:0] out_data_o
);

  import tile_pkg::*;

  logic    [NUM_PORTS-1:0]                 head_empty;
  logic    [NUM_PORTS-1:0]                 head_v;
  packet_t [NUM_PORTS-1:0]                 head_data;
  logic    [NUM_PORTS-1:0][PORT_SEL_W-1:0] head_dir;
  logic    [NUM_PORTS-1:0]                 pop;
  logic    [NUM_PORTS-1:0]                 grant_v;
  logic    [NUM_PORTS-1:0][PORT_SEL_W-1:0] grant_src;
  logic    [NUM_PORTS-1:0]                 out_v_r;
  packet_t [NUM_PORTS-1:0]                 out_data_r;

  // dimension ordered, x first then y
  function automatic logic [PORT_SEL_W-1:0] route_dir(
    input packet_t             pkt,
    input logic [X_CORD_W-1:0] x,
    input logic [Y_CORD_W-1:0] y
  );
    logic [PORT_SEL_W-1:0] dir;
    if (pkt.dest_x > x) begin
      dir = PORT_SEL_W'(DIR_E);
    end else if (pkt.dest_x < x) begin
      dir = PORT_SEL_W'(DIR_W);
    end else if (pkt.dest_y > y) begin
      dir = PORT_SEL_W'(DIR_S);
    end else if (pkt.dest_y < y) begin
      dir = PORT_SEL_W'(DIR_N);
    end else begin
      dir = PORT_SEL_W'(PORT_P);
    end
    return dir;
  endfunction

  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
    link_fifo #(
      .payload_t(packet_t)
    ) i_link_fifo (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .wr_v_i   (in_v_i[i]),
      .wr_data_i(in_data_i[i]),
      .rd_i     (pop[i]),
      .empty_o  (head_empty[i]),
      .full_o   (),
      .rd_data_o(head_data[i])
    );

    assign head_v[i]   = !head_empty[i];
    assign head_dir[i] = route_dir(head_data[i], my_x_i, my_y_i);
  end

  // fixed priority P, W, E, N, S per output
  always_comb begin
    int src;
    grant_v   = '0;
    grant_src = '0;
    pop       = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int k = 0; k < NUM_PORTS; k++) begin
        src = (k + PORT_P) % NUM_PORTS;
        if (!grant_v[o] && head_v[src] && head_dir[src] == PORT_SEL_W'(o)) begin
          grant_v[o]   = 1'b1;
          grant_src[o] = PORT_SEL_W'(src);
          pop[src]     = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_v_r <= '0;
    end else begin
      out_v_r <= grant_v;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (grant_v[o]) out_data_r[o] <= head_data[grant_src[o]];
    end
  end

  assign out_v_o    = out_v_r;
  assign out_data_o = out_data_r;

endmodule

`default_nettype wire

//--- hw/tile_pkg.sv
`default_nettype none

package tile_pkg;

  // coordinate and memory widths
  localparam int X_CORD_W = 4;
  localparam int Y_CORD_W = 4;
  localparam int ADDR_W = 4;
  localparam int DATA_W = 32;
  localparam int DMEM_WORDS = 1 << ADDR_W;

  // mesh directions, also the low router ports
  localparam int NUM_DIRS = 4;
  localparam int DIR_W = 0;
  localparam int DIR_E = 1;
  localparam int DIR_N = 2;
  localparam int DIR_S = 3;

  // local port sits above the four mesh ports
  localparam int PORT_P = 4;
  localparam int NUM_PORTS = NUM_DIRS + 1;
  localparam int PORT_SEL_W = 3;

  // barrier config field positions in the data word
  localparam int BAR_MASK_LSB = 0;
  localparam int BAR_DEST_LSB = BAR_MASK_LSB + NUM_PORTS;

  typedef enum logic [2:0] {
    OP_STORE    = 3'd0,
    OP_LOAD     = 3'd1,
    OP_REPLY    = 3'd2,
    OP_BAR_CFG  = 3'd3,
    OP_BAR_JOIN = 3'd4
  } op_e;

  typedef struct packed {
    op_e                 op;
    logic [X_CORD_W-1:0] dest_x;
    logic [Y_CORD_W-1:0] dest_y;
    logic [X_CORD_W-1:0] src_x;
    logic [Y_CORD_W-1:0] src_y;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
  } packet_t;

endpackage

`default_nettype wire

//--- hw/tile_socket.sv
`default_nettype none

module tile_socket (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic [tile_pkg::X_CORD_W-1:0]   my_x_i,
  input  logic [tile_pkg::Y_CORD_W-1:0]   my_y_i,
  input  logic                             req_v_i,
  input  tile_pkg::packet_t                req_data_i,
  output logic                             reply_v_o,
  output tile_pkg::packet_t                reply_data_o,
  output logic                             bar_join_o,
  output logic [tile_pkg::NUM_PORTS-1:0]  bar_src_mask_o,
  output logic [tile_pkg::PORT_SEL_W-1:0] bar_dest_o,
  input  logic                             bar_release_i
);

  import tile_pkg::*;

  // what a pending load needs to build its reply
  typedef struct packed {
    logic [X_CORD_W-1:0] src_x;
    logic [Y_CORD_W-1:0] src_y;
    logic [ADDR_W-1:0]   addr;
  } load_req_t;

  logic [DATA_W-1:0] dmem_r [DMEM_WORDS];
  logic              store_v;
  logic              load_v;
  logic              cfg_v;
  logic              join_v;
  logic              q_empty;
  load_req_t         load_req;
  load_req_t         head_req;

  // incoming replies fall through every decode below
  assign store_v = req_v_i && (req_data_i.op == OP_STORE);
  assign load_v  = req_v_i && (req_data_i.op == OP_LOAD);
  assign cfg_v   = req_v_i && (req_data_i.op == OP_BAR_CFG);
  assign join_v  = req_v_i && (req_data_i.op == OP_BAR_JOIN);

  always_ff @(posedge clk_i) begin
    if (store_v) dmem_r[req_data_i.addr] <= req_data_i.data;
  end

  assign load_req.src_x = req_data_i.src_x;
  assign load_req.src_y = req_data_i.src_y;
  assign load_req.addr  = req_data_i.addr;

  link_fifo #(
    .payload_t(load_req_t)
  ) i_load_q (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wr_v_i   (load_v),
    .wr_data_i(load_req),
    .rd_i     (reply_v_o),
    .empty_o  (q_empty),
    .full_o   (),
    .rd_data_o(head_req)
  );

  // head turns into a reply the same cycle
  assign reply_v_o = !q_empty;

  always_comb begin
    reply_data_o.op     = OP_REPLY;
    reply_data_o.dest_x = head_req.src_x;
    reply_data_o.dest_y = head_req.src_y;
    reply_data_o.src_x  = my_x_i;
    reply_data_o.src_y  = my_y_i;
    reply_data_o.addr   = head_req.addr;
    reply_data_o.data   = dmem_r[head_req.addr];
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bar_src_mask_o <= '0;
      bar_dest_o     <= '0;
      bar_join_o     <= 1'b0;
    end else begin
      if (cfg_v) begin
        bar_src_mask_o <= req_data_i.data[BAR_MASK_LSB +: NUM_PORTS];
        bar_dest_o     <= req_data_i.data[BAR_DEST_LSB +: PORT_SEL_W];
      end
      // a fresh join wins over a release in the same cycle
      if (join_v) begin
        bar_join_o <= 1'b1;
      end else if (bar_release_i) begin
        bar_join_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire
